//--- bench/afuTb.sv
/*
 * Testbench for the checksum accelerator
 * Clock and reset, LFSR stimulus, host MMIO and memory models,
 * compare tasks, checksum reference model and the closing report
 */

`timescale 1ns/1ps

module afuTb;
  import afuPkg::*;

  localparam int          MAX_OUT      = 4;
  localparam int          RD_TIMEOUT   = 20;
  localparam int          DONE_TIMEOUT = 200;
  localparam int          NUM_JOBS     = 6;
  localparam logic [31:0] SEED         = 32'h82037570;

  logic     pClk;
  logic     arstN;
  logic     mmioWrValid;
  logic     mmioRdValid;
  tMmioAddr mmioAddr;
  tMmioTid  mmioTid;
  tMmioData mmioWrData;
  logic     mmioRspValid;
  tMmioTid  mmioRspTid;
  tMmioData mmioRspData;
  logic     memRdReqValid;
  tMemAddr  memRdReqAddr;
  tMemTag   memRdReqTag;
  logic     memRdAlmFull;
  logic     memRdRspValid;
  tMemTag   memRdRspTag;
  tMmioData memRdRspData;

  // Separate LFSR states keep host and memory streams apart
  logic [31:0] hostLfsr;
  logic [31:0] memLfsr;
  int          checkCount;
  int          mismatchCount;
  int          failCount;
  logic        jobActive;
  logic        almFullOn;
  tMemAddr     expBase;
  int          reqCount;
  int          rspGap;
  tMemAddr     pendAddr[$];
  tMemTag      pendTag[$];

  afuTop #(
    .MAX_OUTSTANDING (MAX_OUT)
  ) dut0 (
    .pClk          (pClk),
    .arstN         (arstN),
    .mmioWrValid   (mmioWrValid),
    .mmioRdValid   (mmioRdValid),
    .mmioAddr      (mmioAddr),
    .mmioTid       (mmioTid),
    .mmioWrData    (mmioWrData),
    .mmioRspValid  (mmioRspValid),
    .mmioRspTid    (mmioRspTid),
    .mmioRspData   (mmioRspData),
    .memRdReqValid (memRdReqValid),
    .memRdReqAddr  (memRdReqAddr),
    .memRdReqTag   (memRdReqTag),
    .memRdAlmFull  (memRdAlmFull),
    .memRdRspValid (memRdRspValid),
    .memRdRspTag   (memRdRspTag),
    .memRdRspData  (memRdRspData)
  );

  always #10 pClk = ~pClk;

  // ============================================================
  // Random numbers and the line data model
  // ============================================================

  // Taps 32, 22, 2 and 1 give a maximal length sequence
  function automatic logic [31:0] lfsrStep(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  // One step per bit taken, newest bit in the LSB
  function automatic logic [63:0] drawBits(inout logic [31:0] state, input int n);
    logic [63:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++)
    begin
      state = lfsrStep(state);
      bits  = {bits[62:0], state[0]};
    end
    return bits;
  endfunction

  // Every line address owns a fixed 64-bit word from its own LFSR walk
  function automatic tMmioData lineData(input tMemAddr addr);
    logic [31:0] walk;
    walk = addr ^ 32'h6D2B_79F5;
    if (walk == '0)
      walk = 32'h1;
    return drawBits(walk, 64);
  endfunction

  // ============================================================
  // Compare tasks and run control
  // ============================================================

  task automatic checkData(input tMmioData got, input tMmioData exp, input string what);
    checkCount++;
    if (got !== exp)
    begin
      mismatchCount++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkAddr(input tMemAddr got, input tMemAddr exp, input string what);
    checkCount++;
    if (got !== exp)
    begin
      mismatchCount++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkTag(input tMemTag got, input tMemTag exp, input string what);
    checkCount++;
    if (got !== exp)
    begin
      mismatchCount++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkTid(input tMmioTid got, input tMmioTid exp, input string what);
    checkCount++;
    if (got !== exp)
    begin
      mismatchCount++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic reportFailure(input string msg);
    failCount++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic finishRun();
    $display("Checks: %0d  mismatches: %0d  other errors: %0d",
             checkCount, mismatchCount, failCount);
    if ((mismatchCount == 0) && (failCount == 0))
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  endtask

  // ============================================================
  // Host MMIO model
  // ============================================================

  task automatic mmioWrite(input tMmioAddr addr, input tMmioData data);
    @(posedge pClk);
    mmioWrValid <= 1'b1;
    mmioAddr    <= addr;
    mmioWrData  <= data;
    @(posedge pClk);
    mmioWrValid <= 1'b0;
  endtask

  // Latency counts cycles from the request cycle, sampled on the falling edge
  task automatic readReg(input tMmioAddr addr, output tMmioData data, output logic ok);
    tMmioTid tid;
    int      waited;
    tid  = tMmioTid'(drawBits(hostLfsr, 9));
    data = '0;
    ok   = 1'b0;
    @(posedge pClk);
    mmioRdValid <= 1'b1;
    mmioAddr    <= addr;
    mmioTid     <= tid;
    @(posedge pClk);
    mmioRdValid <= 1'b0;
    waited = 1;
    @(negedge pClk);
    while (!mmioRspValid && (waited < RD_TIMEOUT))
    begin
      @(negedge pClk);
      waited++;
    end
    if (!mmioRspValid)
      reportFailure("no MMIO read response before the timeout");
    else
    begin
      if (waited != 2)
        reportFailure($sformatf("read response came %0d cycles after request", waited));
      checkTid(mmioRspTid, tid, "response TID");
      data = mmioRspData;
      ok   = 1'b1;
    end
  endtask

  task automatic expectReg(input tMmioAddr addr, input tMmioData exp, input string what);
    tMmioData got;
    logic     ok;
    readReg(addr, got, ok);
    if (ok)
      checkData(got, exp, what);
  endtask

  // Status polling until done, bounded by a poll count
  task automatic waitDone();
    tMmioData status;
    logic     ok;
    int       polls;
    status = '0;
    ok     = 1'b1;
    polls  = 0;
    while (ok && (status[0] != 1'b1) && (polls < DONE_TIMEOUT))
    begin
      readReg(REG_STATUS, status, ok);
      polls++;
    end
    if (ok && (status[0] != 1'b1))
      reportFailure("job did not reach done before the timeout");
    else if (ok)
      checkData(status, 64'd1, "status at done");
  endtask

  // Reference sum is built from the address rule, not from responses
  task automatic runJob(input tLineCount len, input logic restart);
    tMemAddr  base;
    tMmioData expSum;
    int       i;
    base   = tMemAddr'(drawBits(hostLfsr, 32));
    expSum = '0;
    for (i = 0; i < int'(len); i++)
      expSum = expSum + lineData(base + tMemAddr'(i));
    mmioWrite(REG_SRC_BASE, tMmioData'(base));
    mmioWrite(REG_LINE_COUNT, tMmioData'(len));
    expBase   = base;
    reqCount  = 0;
    jobActive = 1'b1;
    mmioWrite(REG_CONTROL, 64'd1);
    // A second start lands while the engine is busy
    if (restart)
      mmioWrite(REG_CONTROL, 64'd1);
    waitDone();
    jobActive = 1'b0;
    expectReg(REG_CHECKSUM, expSum, "job checksum");
    checkData(tMmioData'(reqCount), tMmioData'(len), "request count");
  endtask

  // ============================================================
  // Memory model
  // ============================================================

  // Requests are collected mid-cycle, each address and tag is checked in order
  // Responses leave the list a cycle before the engine counts them,
  // so the list never holds more reads than the engine has in flight
  always @(negedge pClk)
  begin
    if (arstN && memRdReqValid)
    begin
      if (!jobActive)
        reportFailure("memory read request outside a job");
      if (memRdAlmFull)
        reportFailure("memory read request while almost full");
      if (pendAddr.size() >= MAX_OUT)
        reportFailure("more memory reads in flight than the limit");
      checkAddr(memRdReqAddr, expBase + tMemAddr'(reqCount), "request address");
      checkTag(memRdReqTag, tMemTag'(reqCount), "request tag");
      pendAddr.push_back(memRdReqAddr);
      pendTag.push_back(memRdReqTag);
      reqCount++;
    end
  end

  // Answers a random pending request after a random gap
  always @(posedge pClk)
  begin
    int pick;
    memRdAlmFull <= almFullOn && (drawBits(memLfsr, 2) == 64'd0);
    if ((rspGap > 0) || (pendAddr.size() == 0))
    begin
      memRdRspValid <= 1'b0;
      if (rspGap > 0)
        rspGap = rspGap - 1;
    end
    else
    begin
      pick = int'(drawBits(memLfsr, 4)) % pendAddr.size();
      memRdRspValid <= 1'b1;
      memRdRspTag   <= pendTag[pick];
      memRdRspData  <= lineData(pendAddr[pick]);
      pendAddr.delete(pick);
      pendTag.delete(pick);
      rspGap = int'(drawBits(memLfsr, 2));
    end
  end

  // ============================================================
  // Test sequence
  // ============================================================

  initial
  begin
    tMmioData value;
    tMmioAddr addr;
    int       k;
    pClk          = 1'b0;
    arstN         = 1'b0;
    mmioWrValid   = 1'b0;
    mmioRdValid   = 1'b0;
    mmioAddr      = '0;
    mmioTid       = '0;
    mmioWrData    = '0;
    memRdAlmFull  = 1'b0;
    memRdRspValid = 1'b0;
    memRdRspTag   = '0;
    memRdRspData  = '0;
    hostLfsr      = SEED;
    memLfsr       = SEED;
    checkCount    = 0;
    mismatchCount = 0;
    failCount     = 0;
    jobActive     = 1'b0;
    almFullOn     = 1'b0;
    expBase       = '0;
    reqCount      = 0;
    rspGap        = 0;
    repeat (8) @(posedge pClk);
    arstN <= 1'b1;

    // Quiet outputs and cleared registers after reset
    for (k = 0; k < 20; k++)
    begin
      @(negedge pClk);
      if (mmioRspValid || memRdReqValid)
        reportFailure("output strobe active while idle after reset");
    end
    expectReg(REG_STATUS, 64'd0, "status after reset");
    expectReg(REG_SRC_BASE, 64'd0, "source base after reset");
    expectReg(REG_LINE_COUNT, 64'd0, "line count after reset");
    expectReg(REG_CHECKSUM, 64'd0, "checksum after reset");
    expectReg(REG_SCRATCH, 64'd0, "scratch after reset");

    // Constant header and unit ID
    expectReg(REG_DFH, DFH_VALUE, "DFH");
    expectReg(REG_AFU_ID, AFU_ID_VALUE, "unit ID");

    // Random register readback and unmapped indices
    for (k = 0; k < 8; k++)
    begin
      value = drawBits(hostLfsr, 64);
      mmioWrite(REG_SCRATCH, value);
      expectReg(REG_SCRATCH, value, "scratch readback");
      value = drawBits(hostLfsr, 32);
      mmioWrite(REG_SRC_BASE, value);
      expectReg(REG_SRC_BASE, value, "source base readback");
      value = drawBits(hostLfsr, 16);
      mmioWrite(REG_LINE_COUNT, value);
      expectReg(REG_LINE_COUNT, value, "line count readback");
      addr = tMmioAddr'(drawBits(hostLfsr, 16));
      if (addr < 16'd8)
        addr = addr + 16'd8;
      expectReg(addr, 64'd0, "unmapped index");
    end

    // Random jobs of 1 to 40 lines under random back-pressure
    almFullOn = 1'b1;
    for (k = 0; k < NUM_JOBS; k++)
      runJob(tLineCount'(1 + (int'(drawBits(hostLfsr, 6)) % 40)), 1'b0);

    // Empty job, then a start written into a running job
    runJob(16'd0, 1'b0);
    runJob(16'd30, 1'b1);

    finishRun();
  end

endmodule

//--- bench/afuTop_asserts.sv
/*
 * Concurrent checks bound into the checksum engine
 * Issue under almost-full, the in-flight limit, the FSM state
 * after reset and the done and busy flags
 */

`timescale 1ns/1ps

module engineAsserts #(
  parameter int MAX_OUTSTANDING = 16
) (
  input logic                                    pClk,
  input logic                                    arstN,
  input logic                                    memRdAlmFull,
  input logic                                    memRdReqValid,
  input logic                                    busy,
  input afuPkg::tEngineState                     state,
  input logic [$clog2(MAX_OUTSTANDING + 1)-1:0]  outCount
);
  import afuPkg::*;

  // ============================================================
  // Memory request port
  // ============================================================

  // Almost-full holds off issue in the very cycle it is high
  noReqWhenFull: assert property (@(posedge pClk) disable iff (!arstN)
    memRdAlmFull |-> !memRdReqValid)
    else $error("memory request issued while almost full");

  inFlightLimit: assert property (@(posedge pClk) disable iff (!arstN)
    int'(outCount) <= MAX_OUTSTANDING)
    else $error("outstanding reads exceed the limit");

  // ============================================================
  // Engine FSM
  // ============================================================

  // The first sampled cycle out of reset still finds the FSM idle
  idleAfterReset: assert property (@(posedge pClk)
    $rose(arstN) |-> (state == ENG_IDLE))
    else $error("engine not idle after reset");

  doneNotBusy: assert property (@(posedge pClk) disable iff (!arstN)
    !((state == ENG_DONE) && busy))
    else $error("done and busy high together");

endmodule

bind checksumEngine engineAsserts #(
  .MAX_OUTSTANDING (MAX_OUTSTANDING)
) engineChecks (
  .pClk          (pClk),
  .arstN         (arstN),
  .memRdAlmFull  (memRdAlmFull),
  .memRdReqValid (memRdReqValid),
  .busy          (busy),
  .state         (state),
  .outCount      (outCount)
);

//--- compile.f
hdl/afuPkg.sv
hdl/mmioCsrIf.sv
hdl/mmioDecode.sv
hdl/checksumEngine.sv
hdl/mmioResult.sv
hdl/afuTop.sv
bench/afuTop_asserts.sv
bench/afuTb.sv

//--- hdl/afuPkg.sv
/*
 * Shared definitions for the checksum accelerator unit
 * Typedefs for MMIO and memory fields, the engine state enum,
 * the MMIO register indices and the constant header values
 */

package afuPkg;

  // ============================================================
  // Field types
  // ============================================================

  // MMIO register index as seen by the host, one index per 64-bit register
  typedef logic [15:0] tMmioAddr;
  typedef logic [63:0] tMmioData;
  typedef logic [8:0]  tMmioTid;

  // Cache-line address and job length
  typedef logic [31:0] tMemAddr;
  typedef logic [15:0] tLineCount;

  // The tag is the low byte of the line index within the job
  typedef logic [7:0]  tMemTag;

  // Checksum engine FSM states
  typedef enum logic [1:0] {
    ENG_IDLE  = 2'd0,
    ENG_ISSUE = 2'd1,
    ENG_DRAIN = 2'd2,
    ENG_DONE  = 2'd3
  } tEngineState;

  // ============================================================
  // Register map
  // ============================================================

  localparam tMmioAddr REG_DFH        = 16'd0;
  localparam tMmioAddr REG_AFU_ID     = 16'd1;
  localparam tMmioAddr REG_SRC_BASE   = 16'd2;
  localparam tMmioAddr REG_LINE_COUNT = 16'd3;
  localparam tMmioAddr REG_CONTROL    = 16'd4;
  localparam tMmioAddr REG_STATUS     = 16'd5;
  localparam tMmioAddr REG_CHECKSUM   = 16'd6;
  localparam tMmioAddr REG_SCRATCH    = 16'd7;

  // Feature type AFU in [63:60], end of list in bit 40, next offset zero
  localparam tMmioData DFH_VALUE    = 64'h1000_0100_0000_0001;
  localparam tMmioData AFU_ID_VALUE = 64'hC5A3_9E71_4B20_D86F;

endpackage

//--- hdl/afuTop.sv
/*
 * Accelerator top level
 * Host MMIO and memory read ports as plain signals, the register
 * bus and the decoder, checksum engine and response builder
 */

`timescale 1ns/1ps

module afuTop #(
  parameter int MAX_OUTSTANDING = 16
) (
  input  logic              pClk,
  input  logic              arstN,

  // Host MMIO requests
  input  logic              mmioWrValid,
  input  logic              mmioRdValid,
  input  afuPkg::tMmioAddr  mmioAddr,
  input  afuPkg::tMmioTid   mmioTid,
  input  afuPkg::tMmioData  mmioWrData,

  // Host MMIO read responses
  output logic              mmioRspValid,
  output afuPkg::tMmioTid   mmioRspTid,
  output afuPkg::tMmioData  mmioRspData,

  // Memory read port
  output logic              memRdReqValid,
  output afuPkg::tMemAddr   memRdReqAddr,
  output afuPkg::tMemTag    memRdReqTag,
  input  logic              memRdAlmFull,
  input  logic              memRdRspValid,
  input  afuPkg::tMemTag    memRdRspTag,
  input  afuPkg::tMmioData  memRdRspData
);

  // ============================================================
  // Register bus and the three stages
  // ============================================================

  mmioCsrIf csrBus ();

  // Stage one registers the host request
  mmioDecode decodeInst (
    .pClk        (pClk),
    .arstN       (arstN),
    .mmioWrValid (mmioWrValid),
    .mmioRdValid (mmioRdValid),
    .mmioAddr    (mmioAddr),
    .mmioTid     (mmioTid),
    .mmioWrData  (mmioWrData),
    .csr         (csrBus.decode)
  );

  checksumEngine #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) engineInst (
    .pClk          (pClk),
    .arstN         (arstN),
    .csr           (csrBus.execute),
    .memRdAlmFull  (memRdAlmFull),
    .memRdReqValid (memRdReqValid),
    .memRdReqAddr  (memRdReqAddr),
    .memRdReqTag   (memRdReqTag),
    .memRdRspValid (memRdRspValid),
    .memRdRspTag   (memRdRspTag),
    .memRdRspData  (memRdRspData)
  );

  // Stage two builds the read response
  mmioResult resultInst (
    .pClk         (pClk),
    .arstN        (arstN),
    .csr          (csrBus.result),
    .mmioRspValid (mmioRspValid),
    .mmioRspTid   (mmioRspTid),
    .mmioRspData  (mmioRspData)
  );

endmodule

//--- hdl/checksumEngine.sv
/*
 * Checksum engine
 * Job registers, line read issue under almost-full and the
 * outstanding limit, per-tag response tracking and the 64-bit sum
 */

`timescale 1ns/1ps

module checksumEngine #(
  parameter int MAX_OUTSTANDING = 16
) (
  input  logic              pClk,
  input  logic              arstN,
  mmioCsrIf.execute         csr,
  input  logic              memRdAlmFull,
  output logic              memRdReqValid,
  output afuPkg::tMemAddr   memRdReqAddr,
  output afuPkg::tMemTag    memRdReqTag,
  input  logic              memRdRspValid,
  input  afuPkg::tMemTag    memRdRspTag,
  input  afuPkg::tMmioData  memRdRspData
);
  import afuPkg::*;

  localparam int OUT_W = $clog2(MAX_OUTSTANDING + 1);
  localparam int TAGS  = 1 << $bits(tMemTag);

  tEngineState      state;
  tMemAddr          srcBase;
  tLineCount        lineCount;
  tMmioData         scratch;
  tMmioData         checksum;
  tLineCount        issCount;
  tLineCount        rspCount;
  logic [OUT_W-1:0] outCount;
  logic [TAGS-1:0]  pending;
  logic [TAGS-1:0]  setMask;
  logic [TAGS-1:0]  clrMask;
  logic             busy;
  logic             startReq;
  logic             rspAccept;
  logic             lastIssue;

  assign busy     = (state == ENG_ISSUE) || (state == ENG_DRAIN);
  // A start while a job runs is dropped
  assign startReq = csr.wrEn && csr.selControl && csr.wrData[0] && !busy;

  // ============================================================
  // Job and scratch registers
  // ============================================================

  // Base and length are frozen while a job is in flight
  always_ff @(posedge pClk or negedge arstN)
  begin
    if (!arstN)
    begin
      srcBase   <= '0;
      lineCount <= '0;
      scratch   <= '0;
    end
    else if (csr.wrEn)
    begin
      if (csr.selSrcBase && !busy)
        srcBase <= tMemAddr'(csr.wrData);
      if (csr.selLineCount && !busy)
        lineCount <= tLineCount'(csr.wrData);
      if (csr.selScratch)
        scratch <= csr.wrData;
    end
  end

  // ============================================================
  // Request issue
  // ============================================================

  // Requests go out in the same cycle the throttles allow them,
  // so almost-full blocks the very cycle it is high
  assign memRdReqValid = (state == ENG_ISSUE) && (issCount != lineCount) &&
                         (outCount < OUT_W'(MAX_OUTSTANDING)) && !memRdAlmFull;
  assign memRdReqAddr  = srcBase + tMemAddr'(issCount);
  assign memRdReqTag   = tMemTag'(issCount);
  assign lastIssue     = memRdReqValid && (tLineCount'(issCount + 16'd1) == lineCount);

  // At most 255 reads are in flight, so live tags never collide
  // and a response without a pending tag is dropped
  assign rspAccept = memRdRspValid && pending[memRdRspTag];
  assign setMask   = memRdReqValid ? (TAGS'(1) << memRdReqTag) : '0;
  assign clrMask   = rspAccept ? (TAGS'(1) << memRdRspTag) : '0;

  always_ff @(posedge pClk or negedge arstN)
  begin
    if (!arstN)
    begin
      state <= ENG_IDLE;
    end
    else
    begin
      unique case (state)
        ENG_IDLE, ENG_DONE:
          if (startReq)
            state <= ENG_ISSUE;
        // Zero lines leaves issue at once without a request
        ENG_ISSUE:
          if ((lineCount == '0) || lastIssue)
            state <= ENG_DRAIN;
        ENG_DRAIN:
          if (rspCount == lineCount)
            state <= ENG_DONE;
        default:
          state <= ENG_IDLE;
      endcase
    end
  end

  // ============================================================
  // Counters and checksum
  // ============================================================

  // Issue and response counts plus the sum restart with each job
  always_ff @(posedge pClk or negedge arstN)
  begin
    if (!arstN)
    begin
      issCount <= '0;
      rspCount <= '0;
      checksum <= '0;
    end
    else if (startReq)
    begin
      issCount <= '0;
      rspCount <= '0;
      checksum <= '0;
    end
    else
    begin
      if (memRdReqValid)
        issCount <= issCount + tLineCount'(1);
      // Addition is order independent so responses may come in any order
      if (rspAccept)
      begin
        rspCount <= rspCount + tLineCount'(1);
        checksum <= checksum + memRdRspData;
      end
    end
  end

  // In-flight tracking spans jobs and drains to zero by itself
  always_ff @(posedge pClk or negedge arstN)
  begin
    if (!arstN)
    begin
      outCount <= '0;
      pending  <= '0;
    end
    else
    begin
      pending <= (pending & ~clrMask) | setMask;
      if (memRdReqValid && !rspAccept)
        outCount <= outCount + OUT_W'(1);
      else if (!memRdReqValid && rspAccept)
        outCount <= outCount - OUT_W'(1);
    end
  end

  assign csr.srcBase   = srcBase;
  assign csr.lineCount = lineCount;
  assign csr.scratch   = scratch;
  assign csr.checksum  = checksum;
  assign csr.busy      = busy;
  assign csr.done      = (state == ENG_DONE);

endmodule

//--- hdl/mmioCsrIf.sv
/*
 * Register bus between the MMIO decoder, the checksum engine
 * and the read-response builder
 * Carries write strobes, read strobes and register contents
 */

`timescale 1ns/1ps

interface mmioCsrIf;
  import afuPkg::*;

  // Registered host write and its one-hot register selects
  logic      wrEn;
  tMmioData  wrData;
  logic      selSrcBase;
  logic      selLineCount;
  logic      selControl;
  logic      selScratch;

  // Registered host read with the index to return and its transaction ID
  logic      rdEn;
  tMmioAddr  rdSel;
  tMmioTid   rdTid;

  // Current register contents owned by the engine
  tMemAddr   srcBase;
  tLineCount lineCount;
  logic      busy;
  logic      done;
  tMmioData  checksum;
  tMmioData  scratch;

  modport decode (
    output wrEn, wrData, selSrcBase, selLineCount, selControl, selScratch,
    output rdEn, rdSel, rdTid
  );

  modport execute (
    input  wrEn, wrData, selSrcBase, selLineCount, selControl, selScratch,
    output srcBase, lineCount, busy, done, checksum, scratch
  );

  modport result (
    input rdEn, rdSel, rdTid,
    input srcBase, lineCount, busy, done, checksum, scratch
  );

endinterface

//--- hdl/mmioDecode.sv
/*
 * MMIO address decoder
 * Registers the host request, turns the register index into
 * one-hot write selects and forwards the read index and TID
 */

`timescale 1ns/1ps

module mmioDecode (
  input  logic              pClk,
  input  logic              arstN,
  input  logic              mmioWrValid,
  input  logic              mmioRdValid,
  input  afuPkg::tMmioAddr  mmioAddr,
  input  afuPkg::tMmioTid   mmioTid,
  input  afuPkg::tMmioData  mmioWrData,
  mmioCsrIf.decode          csr
);
  import afuPkg::*;

  logic hitSrcBase;
  logic hitLineCount;
  logic hitControl;
  logic hitScratch;

  // ============================================================
  // Write select decode
  // ============================================================

  // Only the writable registers get a select
  // DFH, unit ID, status and checksum are read-only and fall through
  always_comb
  begin
    hitSrcBase   = mmioWrValid && (mmioAddr == REG_SRC_BASE);
    hitLineCount = mmioWrValid && (mmioAddr == REG_LINE_COUNT);
    hitControl   = mmioWrValid && (mmioAddr == REG_CONTROL);
    hitScratch   = mmioWrValid && (mmioAddr == REG_SCRATCH);
  end

  // Strobes and selects are single-cycle pulses one clock after the host strobe
  always_ff @(posedge pClk or negedge arstN)
  begin
    if (!arstN)
    begin
      csr.wrEn         <= 1'b0;
      csr.rdEn         <= 1'b0;
      csr.selSrcBase   <= 1'b0;
      csr.selLineCount <= 1'b0;
      csr.selControl   <= 1'b0;
      csr.selScratch   <= 1'b0;
    end
    else
    begin
      csr.wrEn         <= mmioWrValid;
      csr.rdEn         <= mmioRdValid;
      csr.selSrcBase   <= hitSrcBase;
      csr.selLineCount <= hitLineCount;
      csr.selControl   <= hitControl;
      csr.selScratch   <= hitScratch;
    end
  end

  // ============================================================
  // Payload capture
  // ============================================================

  // Data, index and TID only load when their strobe is present
  always_ff @(posedge pClk)
  begin
    if (mmioWrValid)
      csr.wrData <= mmioWrData;
    if (mmioRdValid)
    begin
      csr.rdSel <= mmioAddr;
      csr.rdTid <= mmioTid;
    end
  end

endmodule

//--- hdl/mmioResult.sv
/*
 * MMIO read-response builder
 * Selects the header, unit ID or a register for a decoded read
 * and returns it one cycle later with its transaction ID
 */

`timescale 1ns/1ps

module mmioResult (
  input  logic              pClk,
  input  logic              arstN,
  mmioCsrIf.result          csr,
  output logic              mmioRspValid,
  output afuPkg::tMmioTid   mmioRspTid,
  output afuPkg::tMmioData  mmioRspData
);
  import afuPkg::*;

  tMmioData rdData;

  // ============================================================
  // Read multiplexer
  // ============================================================

  // Control is a write-only strobe and reads back as zero
  // like any index outside the map
  always_comb
  begin
    case (csr.rdSel)
      REG_DFH:
        rdData = DFH_VALUE;
      REG_AFU_ID:
        rdData = AFU_ID_VALUE;
      REG_SRC_BASE:
        rdData = tMmioData'(csr.srcBase);
      REG_LINE_COUNT:
        rdData = tMmioData'(csr.lineCount);
      // Status has done in bit 0 and busy in bit 1
      REG_STATUS:
        rdData = {62'd0, csr.busy, csr.done};
      REG_CHECKSUM:
        rdData = csr.checksum;
      REG_SCRATCH:
        rdData = csr.scratch;
      default:
        rdData = '0;
    endcase
  end

  // ============================================================
  // Response register
  // ============================================================

  always_ff @(posedge pClk or negedge arstN)
  begin
    if (!arstN)
      mmioRspValid <= 1'b0;
    else
      mmioRspValid <= csr.rdEn;
  end

  // The TID rides along with the data so the host can match it
  always_ff @(posedge pClk)
  begin
    if (csr.rdEn)
    begin
      mmioRspTid  <= csr.rdTid;
      mmioRspData <= rdData;
    end
  end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Builds the checksum accelerator testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator is not installed or not on PATH"
  exit 1
fi

verilator --binary --timing --assert --top-module afuTb \
  -f compile.f -Mdir obj_dir -o afuSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

simOutput=$(./obj_dir/afuSim)
simStatus=$?
echo "$simOutput"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if echo "$simOutput" | grep -qx "NO ERRORS"; then
  exit 0
fi
echo "Simulation reported failure"
exit 1
